/* design/dispatch_cfg_pkg.sv */
// sizes are fixed at ten slots and three groups of three ports; slot index 15 is reserved as the empty marker
package dispatch_cfg_pkg;

  // decoded slots offered by rename each cycle
  localparam int NUM_SLOTS = 10;

  // wide enough for 0..9 plus the empty marker
  localparam int SLOT_IDX_W = 4;

  typedef logic [SLOT_IDX_W-1:0] slot_idx_t;

  localparam slot_idx_t NO_SLOT = slot_idx_t'(15);   // port carries nothing this cycle

  typedef logic [NUM_SLOTS-1:0] slot_mask_t;          // bit i stands for slot i

  // port layout, group g owns ports 3g .. 3g+2
  localparam int PORTS_PER_GROUP = 3;
  localparam int NUM_GROUPS = 3;
  localparam int NUM_PORTS = NUM_GROUPS * PORTS_PER_GROUP;

  // a group never takes more than three slots, so two bits hold the count
  typedef logic [1:0] pick_cnt_t;

endpackage

/* design/dispatch_op_pkg.sv */
// slot classes cover loads, stores, ALU and shift only; vector, FPU and multiply ops do not exist here
package dispatch_op_pkg;

  // opcode class of one decoded slot, as delivered by decode
  typedef enum logic [2:0] {
    OP_NONE,   // empty slot or an op this stage does not dispatch
    OP_ALU,
    OP_SHIFT,
    OP_LOAD,
    OP_STORE
  } op_class_e;

  // rotation pointer of one port group, names the port that takes the next first pick
  typedef enum logic [1:0] {
    ROT_0,
    ROT_1,
    ROT_2
  } rot_e;

  // group numbers, ports of group g are g*3 + 0..2
  localparam int unsigned GRP_MEM = 0;     // loads and stores on ports 0..2
  localparam int unsigned GRP_ALU = 1;     // first three ALU ops on ports 3..5
  localparam int unsigned GRP_SHIFT = 2;   // shifts and ALU overflow on ports 6..8

endpackage

/* design/slot_classifier.sv */
// purely combinational; ALU ops past the third spill into the shift group, no store priority
module slot_classifier
  import dispatch_cfg_pkg::*;
  import dispatch_op_pkg::*;
(
  input  op_class_e  slot_op [NUM_SLOTS],
  output slot_mask_t mem_req,
  output slot_mask_t alu_req,
  output slot_mask_t shift_req
);

  always_comb begin : classify
    logic [SLOT_IDX_W-1:0] alu_seen;

    alu_seen = '0;
    mem_req = '0;
    alu_req = '0;
    shift_req = '0;

    // walk the slots in order so the ALU count follows program order
    for (int i = 0; i < NUM_SLOTS; i++) begin
      case (slot_op[i])
        OP_LOAD, OP_STORE: begin
          mem_req[i] = 1'b1;
        end
        OP_ALU: begin
          if (alu_seen < PORTS_PER_GROUP) begin
            alu_req[i] = 1'b1;
          end else begin
            shift_req[i] = 1'b1;   // ALU ports full, shift units also execute ALU ops
          end
          alu_seen = alu_seen + 1'b1;
        end
        OP_SHIFT: begin
          shift_req[i] = 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  // a slot may ask one group only, otherwise the same op would issue on two ports
  no_overlap: assert final (
    ((mem_req & alu_req) == '0) &&
    ((mem_req & shift_req) == '0) &&
    ((alu_req & shift_req) == '0)
  ) else $error("slot requests more than one port group");

endmodule

/* design/group_picker.sv */
// picks at most three slots per cycle in ascending slot order; the rest are retried upstream
module group_picker
  import dispatch_cfg_pkg::*;
(
  input  slot_mask_t req,
  output slot_idx_t  pick [PORTS_PER_GROUP],
  output pick_cnt_t  pick_cnt
);

  always_comb begin : find
    pick_cnt_t found;

    found = '0;
    for (int k = 0; k < PORTS_PER_GROUP; k++) begin
      pick[k] = NO_SLOT;   // unused picks stay empty
    end

    // lowest index first, stop filling once all three picks are taken
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (req[i] && (found < 2'd3)) begin
        pick[found] = slot_idx_t'(i);
        found = found + 1'b1;
      end
    end

    pick_cnt = found;   // popcount of req, saturated at three
  end

  // empty picks only trail the valid ones and valid picks keep slot order
  for (genvar k = 1; k < PORTS_PER_GROUP; k++) begin : g_order
    ascending: assert final (
      (pick[k] == NO_SLOT) ||
      ((pick[k-1] != NO_SLOT) && (pick[k-1] < pick[k]))
    ) else $error("pick %0d out of slot order", k);
  end

  // the rotator advances by pick_cnt, so it has to agree with what was actually placed
  cnt_match: assert final (
    $countones({pick[2] != NO_SLOT, pick[1] != NO_SLOT, pick[0] != NO_SLOT}) == pick_cnt
  ) else $error("pick_cnt disagrees with number of valid picks");

endmodule

/* design/port_rotator.sv */
// pointers move one cycle after the picks that move them; stall freezes pointers, not outputs
module port_rotator
  import dispatch_cfg_pkg::*;
  import dispatch_op_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      stall,
  input  slot_idx_t pick [NUM_GROUPS][PORTS_PER_GROUP],
  input  pick_cnt_t pick_cnt [NUM_GROUPS],
  output slot_idx_t port_slot [NUM_PORTS],
  output slot_mask_t slot_taken
);

  rot_e rot [NUM_GROUPS];

  // (r + n) mod 3, n is at most 3 so one correction step is enough
  function automatic rot_e rot_add(rot_e r, pick_cnt_t n);
    logic [2:0] sum;

    sum = {1'b0, r} + {1'b0, n};
    if (sum >= PORTS_PER_GROUP) begin
      sum = sum - 3'd3;
    end
    return rot_e'(sum[1:0]);
  endfunction

  always_comb begin : route
    rot_e pos;

    for (int p = 0; p < NUM_PORTS; p++) begin
      port_slot[p] = NO_SLOT;
    end
    slot_taken = '0;

    for (int g = 0; g < NUM_GROUPS; g++) begin
      for (int k = 0; k < PORTS_PER_GROUP; k++) begin
        pos = rot_add(rot[g], pick_cnt_t'(k));   // k-th pick lands k ports after the pointer
        port_slot[g * PORTS_PER_GROUP + pos] = pick[g][k];
        if (pick[g][k] != NO_SLOT) begin
          slot_taken[pick[g][k]] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int g = 0; g < NUM_GROUPS; g++) begin
        rot[g] <= ROT_0;
      end
    end else if (!stall) begin
      // next cycle starts on the port after the last one used
      for (int g = 0; g < NUM_GROUPS; g++) begin
        rot[g] <= rot_add(rot[g], pick_cnt[g]);
      end
    end
  end

  for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_check
    // encoding 3 would route the first pick into the next group's ports
    rot_legal: assert property (
      @(posedge clk) disable iff (rst)
      rot[g] inside {ROT_0, ROT_1, ROT_2}
    ) else $error("group %0d rotation pointer left its legal range", g);

    // picks shown during a stall are not issued, so the pointer must not move past them
    rot_hold: assert property (
      @(posedge clk) disable iff (rst)
      stall |=> $stable(rot[g])
    ) else $error("group %0d rotation pointer moved under stall", g);
  end

endmodule

/* design/dispatch_top.sv */
// combinational from slot_op to port_slot and slot_taken; untaken slots are not held here and must be replayed
module dispatch_top
  import dispatch_cfg_pkg::*;
  import dispatch_op_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       stall,
  input  op_class_e  slot_op [NUM_SLOTS],
  output slot_idx_t  port_slot [NUM_PORTS],
  output slot_mask_t slot_taken
);

  slot_mask_t req [NUM_GROUPS];                       // indexed by group number
  slot_idx_t  pick [NUM_GROUPS][PORTS_PER_GROUP];
  pick_cnt_t  pick_cnt [NUM_GROUPS];

  slot_classifier classifier_i (
    .slot_op   (slot_op),
    .mem_req   (req[GRP_MEM]),
    .alu_req   (req[GRP_ALU]),
    .shift_req (req[GRP_SHIFT])
  );

  // one picker per group, all three identical
  for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_pick
    group_picker picker_i (
      .req      (req[g]),
      .pick     (pick[g]),
      .pick_cnt (pick_cnt[g])
    );
  end

  port_rotator rotator_i (
    .clk        (clk),
    .rst        (rst),
    .stall      (stall),
    .pick       (pick),
    .pick_cnt   (pick_cnt),
    .port_slot  (port_slot),
    .slot_taken (slot_taken)
  );

endmodule

/* bench/dispatch_tests.svh */
// directed and random tests, included inside dispatch_tb; every test resets the DUT first
`ifndef DISPATCH_TESTS_SVH
`define DISPATCH_TESTS_SVH

task automatic clear_stim();
  for (int i = 0; i < NUM_SLOTS; i++) begin
    stim_op[i] = OP_NONE;
  end
endtask

// apply stim_op and stall on the falling edge, then compare everything with the model
task automatic drive_cycle(input logic stall_v);
  @(negedge clk);
  stall = stall_v;
  for (int i = 0; i < NUM_SLOTS; i++) begin
    slot_op[i] = stim_op[i];
  end
  #5;
  check_model();
endtask

task automatic reset_dut();
  @(negedge clk);
  rst = 1'b1;
  stall = 1'b0;
  clear_stim();
  for (int i = 0; i < NUM_SLOTS; i++) begin
    slot_op[i] = OP_NONE;
  end
  repeat (RESET_CYCLES) @(negedge clk);
  rst = 1'b0;
endtask

task automatic test_reset_state();
  reset_dut();
  drive_cycle(1'b0);
  for (int p = 0; p < NUM_PORTS; p++) begin
    check_port_slot(p, port_slot[p], NO_SLOT);
  end
  check_taken(slot_taken, '0);

  stim_op[4] = OP_LOAD;
  drive_cycle(1'b0);
  check_port_slot(0, port_slot[0], slot_idx_t'(4));
  check_taken(slot_taken, slot_mask_t'(1) << 4);
endtask

task automatic test_group_routing();
  reset_dut();
  stim_op[0] = OP_ALU;
  stim_op[1] = OP_ALU;
  stim_op[2] = OP_SHIFT;
  stim_op[3] = OP_ALU;
  stim_op[4] = OP_ALU;   // fourth and fifth ALU go to the shift group
  stim_op[5] = OP_ALU;
  drive_cycle(1'b0);
  check_port_slot(3, port_slot[3], slot_idx_t'(0));
  check_port_slot(4, port_slot[4], slot_idx_t'(1));
  check_port_slot(5, port_slot[5], slot_idx_t'(3));
  check_port_slot(6, port_slot[6], slot_idx_t'(2));
  check_port_slot(7, port_slot[7], slot_idx_t'(4));
  check_port_slot(8, port_slot[8], slot_idx_t'(5));
  check_taken(slot_taken, slot_mask_t'(10'b00_0011_1111));
endtask

task automatic test_rotation();
  reset_dut();
  stim_op[1] = OP_LOAD;
  stim_op[6] = OP_LOAD;
  drive_cycle(1'b0);
  check_port_slot(0, port_slot[0], slot_idx_t'(1));
  check_port_slot(1, port_slot[1], slot_idx_t'(6));
  check_port_slot(2, port_slot[2], NO_SLOT);

  clear_stim();
  stim_op[3] = OP_LOAD;
  drive_cycle(1'b0);
  check_port_slot(2, port_slot[2], slot_idx_t'(3));

  clear_stim();
  stim_op[0] = OP_LOAD;
  drive_cycle(1'b0);
  check_port_slot(0, port_slot[0], slot_idx_t'(0));   // wrapped around the group
endtask

task automatic test_stall();
  reset_dut();
  stim_op[2] = OP_LOAD;
  drive_cycle(1'b0);
  check_port_slot(0, port_slot[0], slot_idx_t'(2));

  clear_stim();
  stim_op[5] = OP_LOAD;
  repeat (3) begin
    drive_cycle(1'b1);
    check_port_slot(1, port_slot[1], slot_idx_t'(5));   // pointer frozen on port 1
  end

  clear_stim();
  stim_op[7] = OP_LOAD;
  drive_cycle(1'b0);
  check_port_slot(1, port_slot[1], slot_idx_t'(7));

  clear_stim();
  stim_op[8] = OP_LOAD;
  drive_cycle(1'b0);
  check_port_slot(2, port_slot[2], slot_idx_t'(8));
endtask

task automatic test_group_overflow();
  reset_dut();
  stim_op[1] = OP_STORE;
  stim_op[3] = OP_STORE;
  stim_op[4] = OP_STORE;
  stim_op[7] = OP_STORE;
  stim_op[9] = OP_STORE;
  drive_cycle(1'b0);
  check_port_slot(0, port_slot[0], slot_idx_t'(1));
  check_port_slot(1, port_slot[1], slot_idx_t'(3));
  check_port_slot(2, port_slot[2], slot_idx_t'(4));
  check_taken(slot_taken, slot_mask_t'(10'b00_0001_1010));   // slots 7 and 9 wait upstream
endtask

task automatic test_random_mix();
  int r;

  reset_dut();
  for (int c = 0; c < RANDOM_CYCLES; c++) begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      r = $random(seed);
      stim_op[i] = op_class_e'($unsigned(r) % 5);
    end
    r = $random(seed);
    drive_cycle(r[1:0] == 2'b00);   // stall about one cycle in four
  end
endtask

`endif

/* bench/dispatch_tb.sv */
// self-checking testbench for dispatch_top; inputs change on the falling edge, outputs are sampled 5 ns later
module dispatch_tb
  import dispatch_cfg_pkg::*;
  import dispatch_op_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 10;
  localparam int NUM_RESETS = 6;           // every test starts from a fresh reset
  localparam int DIRECTED_CYCLES = 13;
  localparam int RANDOM_CYCLES = 200;
  localparam int TEST_CYCLES = NUM_RESETS * (RESET_CYCLES + 1) + DIRECTED_CYCLES + RANDOM_CYCLES;
  localparam int WATCHDOG_NS = (TEST_CYCLES + 50) * 20;

  logic       clk;
  logic       rst;
  logic       stall;
  op_class_e  slot_op [NUM_SLOTS];
  slot_idx_t  port_slot [NUM_PORTS];
  slot_mask_t slot_taken;

  op_class_e  stim_op [NUM_SLOTS];         // next pattern, applied by drive_cycle
  int         exp_rot [NUM_GROUPS];        // model rotation pointers
  slot_idx_t  exp_port [NUM_PORTS];
  slot_mask_t exp_taken;
  int         error_count = 0;
  int         seed;

  dispatch_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .stall      (stall),
    .slot_op    (slot_op),
    .port_slot  (port_slot),
    .slot_taken (slot_taken)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // group a slot belongs to, or -1 when it asks for no port
  function automatic int slot_group(int i);
    int alu_before;

    alu_before = 0;
    for (int j = 0; j < i; j++) begin
      if (slot_op[j] == OP_ALU) begin
        alu_before++;
      end
    end
    case (slot_op[i])
      OP_LOAD, OP_STORE: return GRP_MEM;
      OP_ALU: return (alu_before < PORTS_PER_GROUP) ? GRP_ALU : GRP_SHIFT;   // fourth ALU and later spill
      OP_SHIFT: return GRP_SHIFT;
      default: return -1;
    endcase
  endfunction

  function automatic int group_count(int g);
    int n;

    n = 0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (slot_group(i) == g) begin
        n++;
      end
    end
    return (n > PORTS_PER_GROUP) ? PORTS_PER_GROUP : n;
  endfunction

  // expected ports and taken mask for the current slot_op and model pointers
  function automatic void model_route();
    int k;

    for (int p = 0; p < NUM_PORTS; p++) begin
      exp_port[p] = NO_SLOT;
    end
    exp_taken = '0;
    for (int g = 0; g < NUM_GROUPS; g++) begin
      k = 0;
      for (int i = 0; i < NUM_SLOTS; i++) begin
        if (slot_group(i) == g && k < PORTS_PER_GROUP) begin
          exp_port[g * PORTS_PER_GROUP + (exp_rot[g] + k) % PORTS_PER_GROUP] = slot_idx_t'(i);
          exp_taken[i] = 1'b1;
          k++;
        end
      end
    end
  endfunction

  always @(posedge clk) begin : rot_model
    for (int g = 0; g < NUM_GROUPS; g++) begin
      if (rst) begin
        exp_rot[g] <= 0;
      end else if (!stall) begin
        exp_rot[g] <= (exp_rot[g] + group_count(g)) % PORTS_PER_GROUP;
      end
    end
  end

  task automatic check_port_slot(input int port, input slot_idx_t got, input slot_idx_t exp);
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t ns: port %0d shows slot %0d, expected slot %0d", $time, port, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "port slot mismatch");
    end
  endtask

  task automatic check_taken(input slot_mask_t got, input slot_mask_t exp);
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t ns: slot_taken is %b, expected %b", $time, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "slot_taken mismatch");
    end
  endtask

  task automatic check_model();
    model_route();
    for (int p = 0; p < NUM_PORTS; p++) begin
      check_port_slot(p, port_slot[p], exp_port[p]);
    end
    check_taken(slot_taken, exp_taken);
  endtask

  `include "dispatch_tests.svh"

  initial begin : main
    seed = 32'h8820_c971;
    rst = 1'b1;
    stall = 1'b0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      slot_op[i] = OP_NONE;
      stim_op[i] = OP_NONE;
    end

    test_reset_state();
    test_group_routing();
    test_rotation();
    test_stall();
    test_group_overflow();
    test_random_mix();

    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped by the watchdog");
  end

endmodule

/* dispatch.f */
+incdir+bench
design/dispatch_cfg_pkg.sv
design/dispatch_op_pkg.sv
design/slot_classifier.sv
design/group_picker.sv
design/port_rotator.sv
design/dispatch_top.sv
bench/dispatch_tb.sv

/* Bender.yml */
package:
  name: dispatch

sources:
  - files:
      - design/dispatch_cfg_pkg.sv
      - design/dispatch_op_pkg.sv
      - design/slot_classifier.sv
      - design/group_picker.sv
      - design/port_rotator.sv
      - design/dispatch_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/dispatch_tb.sv
